//--- vlog.f
+incdir+rtl
rtl/dma_pkg.sv
rtl/dma_bar_ram.sv
rtl/dma_rx_ctrl.sv
rtl/dma_apb_regs.sv
rtl/dma_mwr_tx.sv
rtl/dma_top.sv
sim/dma_assert.sv
sim/tb_dma_top.sv

//--- Bender.yml
package:
  name: pcie_ep_dma

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/dma_pkg.sv
      - rtl/dma_bar_ram.sv
      - rtl/dma_rx_ctrl.sv
      - rtl/dma_apb_regs.sv
      - rtl/dma_mwr_tx.sv
      - rtl/dma_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/dma_assert.sv
      - sim/tb_dma_top.sv

//--- sim/tb_dma_top.sv
`timescale 1ns/1ps
`include "dma_defs.svh"

module tb_dma_top;

    // rx and tx tlps of up to 17 beats, tx at half rate, apb polling, wide margin
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int POLL_LIMIT     = 500;
    localparam int N_RAND_TLP     = 8;

    logic               clk;
    logic               i_arst_n;
    logic [7:0]         i_cfg_pbus_num;
    logic [4:0]         i_cfg_pbus_dev_num;
    logic               i_axis_master_tvld;
    dma_pkg::tlp_beat_t i_axis_master_tdata;
    logic               i_axis_master_tlast;
    logic               o_axis_master_trdy;
    logic               i_axis_slave_trdy;
    logic               o_axis_slave_tvld;
    dma_pkg::tlp_beat_t o_axis_slave_tdata;
    logic               o_axis_slave_tlast;
    logic               i_apb_psel;
    dma_pkg::apb_addr_t i_apb_paddr;
    dma_pkg::apb_data_t i_apb_pwdata;
    logic               i_apb_pwrite;
    logic               i_apb_penable;
    logic               o_apb_prdy;
    dma_pkg::apb_data_t o_apb_prdata;

    // reference model
    logic [127:0] model_mem [64];
    int           rx_cnt_exp;
    int           done_cnt_exp;

    logic [127:0] out_data [$];
    logic         out_last [$];
    int           starts [N_RAND_TLP];
    int           counts [N_RAND_TLP];
    bit           bp_en;
    int           err_cnt;
    int           check_cnt;
    int           cycle_cnt;
    int unsigned  seed_val;

    dma_top i_dma_top (.*);

    bind dma_top dma_assert u_dma_assert (
        .clk                (clk),
        .i_arst_n           (i_arst_n),
        .i_axis_slave_trdy  (i_axis_slave_trdy),
        .o_axis_slave_tvld  (o_axis_slave_tvld),
        .o_axis_slave_tdata (o_axis_slave_tdata),
        .o_axis_slave_tlast (o_axis_slave_tlast),
        .i_apb_psel         (i_apb_psel),
        .i_apb_penable      (i_apb_penable),
        .o_apb_prdy         (o_apb_prdy)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ********************
    // back-pressure, stream capture, timeout
    initial
    begin
        forever
        begin
            @(posedge clk);
            #1;
            if (bp_en)
            begin
                i_axis_slave_trdy = $urandom_range(0, 1);
            end
            else
            begin
                i_axis_slave_trdy = 1'b1;
            end
        end
    end

    always @(negedge clk)
    begin
        if (i_arst_n && o_axis_slave_tvld && i_axis_slave_trdy)
        begin
            out_data.push_back(o_axis_slave_tdata);
            out_last.push_back(o_axis_slave_tlast);
        end
    end

    always @(posedge clk)
    begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        check_cnt++;
        if (act !== exp)
        begin
            err_cnt++;
            $display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic write_reg(input dma_pkg::apb_addr_t addr, input dma_pkg::apb_data_t data);
        i_apb_psel   = 1'b1;
        i_apb_paddr  = addr;
        i_apb_pwdata = data;
        i_apb_pwrite = 1'b1;
        @(posedge clk);
        #1;
        i_apb_penable = 1'b1;
        @(posedge clk);
        #1;
        i_apb_psel    = 1'b0;
        i_apb_penable = 1'b0;
        i_apb_pwrite  = 1'b0;
    endtask

    task automatic read_reg(input dma_pkg::apb_addr_t addr, output dma_pkg::apb_data_t data);
        i_apb_psel   = 1'b1;
        i_apb_paddr  = addr;
        i_apb_pwrite = 1'b0;
        @(posedge clk);
        #1;
        i_apb_penable = 1'b1;
        // prdata is combinational in the access phase
        @(negedge clk);
        data = o_apb_prdata;
        check_value("o_apb_prdy", 1, o_apb_prdy);
        @(posedge clk);
        #1;
        i_apb_psel    = 1'b0;
        i_apb_penable = 1'b0;
    endtask

    function automatic logic [127:0] fill_line(input int line);
        return {4{line ^ 32'h5A5A_0000}};
    endfunction

    function automatic logic [127:0] rand_line();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    task automatic send_beat(input logic [127:0] data, input logic last);
        i_axis_master_tvld  = 1'b1;
        i_axis_master_tdata = data;
        i_axis_master_tlast = last;
        // rx side never back-pressures after reset
        @(negedge clk);
        check_value("o_axis_master_trdy", 1, o_axis_master_trdy);
        @(posedge clk);
        #1;
    endtask

    task automatic send_tlp(input logic [7:0] ttype, input logic [31:0] addr,
                            input int nbeats, input bit fill);
        logic [127:0] hdr;
        logic [127:0] data;
        int           line;
        int           i;
        hdr        = '0;
        hdr[7:0]   = ttype;
        hdr[17:8]  = 10'(nbeats * 4);
        hdr[63:32] = addr;
        line       = addr[9:4];
        send_beat(hdr, 1'b0);
        for (i = 0; i < nbeats; i++)
        begin
            data = fill ? fill_line(line) : rand_line();
            send_beat(data, i == nbeats - 1);
            if (ttype == `DMA_TYPE_MWR32)
            begin
                model_mem[line] = data;
            end
            line = (line + 1) % 64;
        end
        i_axis_master_tvld  = 1'b0;
        i_axis_master_tlast = 1'b0;
        if (ttype == `DMA_TYPE_MWR32)
        begin
            rx_cnt_exp++;
        end
    endtask

    task automatic run_tx(input logic [31:0] dst, input int src, input int cnt,
                          input bit double_start);
        dma_pkg::apb_data_t rd;
        logic [127:0]       hdr;
        int                 polls;
        int                 k;
        out_data.delete();
        out_last.delete();
        write_reg(`DMA_REG_DST, dst);
        write_reg(`DMA_REG_SRC, {19'h0, 5'(cnt), 2'b00, 6'(src)});
        write_reg(`DMA_REG_CTRL, 32'h1);
        if (double_start)
        begin
            // lands while the first tlp is in flight
            write_reg(`DMA_REG_CTRL, 32'h1);
        end
        read_reg(`DMA_REG_CTRL, rd);
        check_value("CTRL busy", 1, rd[0]);
        polls = 0;
        while (rd[0] && polls < POLL_LIMIT)
        begin
            read_reg(`DMA_REG_CTRL, rd);
            polls++;
        end
        if (rd[0])
        begin
            err_cnt++;
            $display("ERROR at %0t: transmit still busy after %0d polls", $time, POLL_LIMIT);
        end
        done_cnt_exp++;
        check_value("o_axis_slave beats", cnt + 1, out_data.size());
        if (out_data.size() > 0)
        begin
            hdr = out_data[0];
            check_value("header type", `DMA_TYPE_MWR32, hdr[7:0]);
            check_value("header length", cnt * 4, hdr[17:8]);
            check_value("header address", dst, hdr[63:32]);
            check_value("header requester id", {i_cfg_pbus_num, i_cfg_pbus_dev_num, 3'b000},
                        hdr[79:64]);
            check_value("header tlast", 0, out_last[0]);
        end
        for (k = 1; k < out_data.size() && k <= cnt; k++)
        begin
            check_value($sformatf("o_axis_slave_tdata beat %0d", k),
                        model_mem[(src + k - 1) % 64], out_data[k]);
            check_value($sformatf("o_axis_slave_tlast beat %0d", k), k == cnt, out_last[k]);
        end
    endtask

    task automatic end_test(input string name, input int err_start);
        $display("test %-18s done, %0d errors", name, err_cnt - err_start);
    endtask

    // ********************
    // test sequence
    initial
    begin
        dma_pkg::apb_data_t rd;
        logic [31:0]        wval;
        logic [31:0]        addr;
        logic [7:0]         ttype;
        int                 err_start;
        int                 i;
        seed_val            = $urandom(32'h8821_18fe);
        i_arst_n            = 1'b0;
        i_cfg_pbus_num      = $urandom;
        i_cfg_pbus_dev_num  = $urandom;
        i_axis_master_tvld  = 1'b0;
        i_axis_master_tdata = '0;
        i_axis_master_tlast = 1'b0;
        i_axis_slave_trdy   = 1'b1;
        i_apb_psel          = 1'b0;
        i_apb_paddr         = '0;
        i_apb_pwdata        = '0;
        i_apb_pwrite        = 1'b0;
        i_apb_penable       = 1'b0;
        bp_en               = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        // stream input not ready while in reset
        check_value("o_axis_master_trdy", 0, o_axis_master_trdy);
        i_arst_n = 1'b1;
        @(posedge clk);
        #1;

        err_start = err_cnt;
        for (i = 0; i < 4; i++)
        begin
            wval = $urandom;
            write_reg(`DMA_REG_DST, wval);
            read_reg(`DMA_REG_DST, rd);
            check_value("DST", wval, rd);
            wval = $urandom;
            write_reg(`DMA_REG_SRC, wval);
            read_reg(`DMA_REG_SRC, rd);
            check_value("SRC", wval & 32'h0000_1F3F, rd);
        end
        end_test("register access", err_start);

        err_start = err_cnt;
        // known contents in every line first
        for (i = 0; i < 4; i++)
        begin
            send_tlp(`DMA_TYPE_MWR32, i * 256, 16, 1'b1);
        end
        for (i = 0; i < N_RAND_TLP; i++)
        begin
            addr      = $urandom;
            starts[i] = addr[9:4];
            counts[i] = $urandom_range(1, 16);
            send_tlp(`DMA_TYPE_MWR32, addr, counts[i], 1'b0);
        end
        for (i = 0; i < N_RAND_TLP; i++)
        begin
            run_tx($urandom, starts[i], counts[i], 1'b0);
        end
        end_test("receive to memory", err_start);

        err_start = err_cnt;
        bp_en = 1'b1;
        for (i = 0; i < N_RAND_TLP; i++)
        begin
            run_tx($urandom, $urandom_range(0, 63), $urandom_range(1, 16), 1'b0);
        end
        bp_en = 1'b0;
        end_test("transmit format", err_start);

        err_start = err_cnt;
        for (i = 0; i < 4; i++)
        begin
            ttype = $urandom;
            if (ttype == `DMA_TYPE_MWR32)
            begin
                ttype = 8'h00;
            end
            addr      = $urandom;
            starts[i] = addr[9:4];
            counts[i] = $urandom_range(1, 16);
            send_tlp(ttype, addr, counts[i], 1'b0);
        end
        read_reg(`DMA_REG_RX_CNT, rd);
        check_value("RX_CNT", rx_cnt_exp, rd);
        for (i = 0; i < 4; i++)
        begin
            run_tx($urandom, starts[i], counts[i], 1'b0);
        end
        end_test("dropped types", err_start);

        err_start = err_cnt;
        read_reg(`DMA_REG_RX_CNT, rd);
        check_value("RX_CNT", rx_cnt_exp, rd);
        read_reg(`DMA_REG_DONE_CNT, rd);
        check_value("DONE_CNT", done_cnt_exp, rd);
        bp_en = 1'b1;
        run_tx($urandom, $urandom_range(0, 63), 16, 1'b1);
        bp_en = 1'b0;
        read_reg(`DMA_REG_DONE_CNT, rd);
        check_value("DONE_CNT", done_cnt_exp, rd);
        end_test("counters and busy", err_start);

        $display("checks run: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0)
        begin
            $display("ALL CHECKS PASSED");
        end
        else
        begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- sim/dma_assert.sv
`timescale 1ns/1ps

module dma_assert (
    input logic               clk,
    input logic               i_arst_n,
    input logic               i_axis_slave_trdy,
    input logic               o_axis_slave_tvld,
    input dma_pkg::tlp_beat_t o_axis_slave_tdata,
    input logic               o_axis_slave_tlast,
    input logic               i_apb_psel,
    input logic               i_apb_penable,
    input logic               o_apb_prdy
);

    // ********************
    // output stream holds a stalled beat
    a_stall_hold : assert property (
        @(posedge clk) disable iff (!i_arst_n)
        (o_axis_slave_tvld && !i_axis_slave_trdy) |=>
            (o_axis_slave_tvld && $stable(o_axis_slave_tdata) && $stable(o_axis_slave_tlast))
    ) else $error("stream beat changed while stalled");

    // no wait states, ready only in the access phase
    a_prdy_access : assert property (
        @(posedge clk) o_apb_prdy |-> (i_apb_psel && i_apb_penable)
    ) else $error("pready high outside an access phase");

    // ********************
    // quiet output in reset
    a_rst_tvld : assert property (
        @(posedge clk) !i_arst_n |-> !o_axis_slave_tvld
    ) else $error("tvld high during reset");

endmodule

//--- rtl/dma_top.sv
`timescale 1ns/1ps

module dma_top (
    input  logic               clk,
    input  logic               i_arst_n,
    input  logic [7:0]         i_cfg_pbus_num,
    input  logic [4:0]         i_cfg_pbus_dev_num,
    // ********************
    // stream in
    input  logic               i_axis_master_tvld,
    input  dma_pkg::tlp_beat_t i_axis_master_tdata,
    input  logic               i_axis_master_tlast,
    output logic               o_axis_master_trdy,
    // stream out
    input  logic               i_axis_slave_trdy,
    output logic               o_axis_slave_tvld,
    output dma_pkg::tlp_beat_t o_axis_slave_tdata,
    output logic               o_axis_slave_tlast,
    // ********************
    // apb
    input  logic               i_apb_psel,
    input  dma_pkg::apb_addr_t i_apb_paddr,
    input  dma_pkg::apb_data_t i_apb_pwdata,
    input  logic               i_apb_pwrite,
    input  logic               i_apb_penable,
    output logic               o_apb_prdy,
    output dma_pkg::apb_data_t o_apb_prdata
);

    // rx to memory
    logic                wr_en;
    dma_pkg::ram_idx_t   wr_idx;
    dma_pkg::tlp_beat_t  wr_data;
    logic                rx_done;
    // tx to memory
    logic                rd_en;
    dma_pkg::ram_idx_t   rd_idx;
    dma_pkg::tlp_beat_t  rd_data;
    // registers to tx
    logic                start;
    dma_pkg::host_addr_t dst_addr;
    dma_pkg::ram_idx_t   src_idx;
    dma_pkg::beat_cnt_t  beat_cnt;
    logic                tx_busy;
    logic                tx_done;

    dma_rx_ctrl u_dma_rx_ctrl (
        .clk       (clk),
        .i_arst_n  (i_arst_n),
        .i_tvld    (i_axis_master_tvld),
        .i_tdata   (i_axis_master_tdata),
        .i_tlast   (i_axis_master_tlast),
        .o_trdy    (o_axis_master_trdy),
        .o_wr_en   (wr_en),
        .o_wr_idx  (wr_idx),
        .o_wr_data (wr_data),
        .o_rx_done (rx_done)
    );

    dma_bar_ram u_dma_bar_ram (
        .clk       (clk),
        .i_wr_en   (wr_en),
        .i_wr_idx  (wr_idx),
        .i_wr_data (wr_data),
        .i_rd_en   (rd_en),
        .i_rd_idx  (rd_idx),
        .o_rd_data (rd_data)
    );

    dma_apb_regs u_dma_apb_regs (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_apb_psel    (i_apb_psel),
        .i_apb_paddr   (i_apb_paddr),
        .i_apb_pwdata  (i_apb_pwdata),
        .i_apb_pwrite  (i_apb_pwrite),
        .i_apb_penable (i_apb_penable),
        .i_tx_busy     (tx_busy),
        .i_tx_done     (tx_done),
        .i_rx_done     (rx_done),
        .o_apb_prdy    (o_apb_prdy),
        .o_apb_prdata  (o_apb_prdata),
        .o_start       (start),
        .o_dst_addr    (dst_addr),
        .o_src_idx     (src_idx),
        .o_beat_cnt    (beat_cnt)
    );

    dma_mwr_tx u_dma_mwr_tx (
        .clk                (clk),
        .i_arst_n           (i_arst_n),
        .i_cfg_pbus_num     (i_cfg_pbus_num),
        .i_cfg_pbus_dev_num (i_cfg_pbus_dev_num),
        .i_start            (start),
        .i_dst_addr         (dst_addr),
        .i_src_idx          (src_idx),
        .i_beat_cnt         (beat_cnt),
        .i_rd_data          (rd_data),
        .i_trdy             (i_axis_slave_trdy),
        .o_rd_en            (rd_en),
        .o_rd_idx           (rd_idx),
        .o_tvld             (o_axis_slave_tvld),
        .o_tdata            (o_axis_slave_tdata),
        .o_tlast            (o_axis_slave_tlast),
        .o_busy             (tx_busy),
        .o_tx_done          (tx_done)
    );

endmodule

//--- rtl/dma_mwr_tx.sv
`timescale 1ns/1ps
`include "dma_defs.svh"

module dma_mwr_tx (
    input  logic                clk,
    input  logic                i_arst_n,
    input  logic [7:0]          i_cfg_pbus_num,
    input  logic [4:0]          i_cfg_pbus_dev_num,
    input  logic                i_start,
    input  dma_pkg::host_addr_t i_dst_addr,
    input  dma_pkg::ram_idx_t   i_src_idx,
    input  dma_pkg::beat_cnt_t  i_beat_cnt,
    input  dma_pkg::tlp_beat_t  i_rd_data,
    input  logic                i_trdy,
    output logic                o_rd_en,
    output dma_pkg::ram_idx_t   o_rd_idx,
    output logic                o_tvld,
    output dma_pkg::tlp_beat_t  o_tdata,
    output logic                o_tlast,
    output logic                o_busy,
    output logic                o_tx_done
);

    dma_pkg::tx_state_t state_q;
    dma_pkg::beat_cnt_t start_cnt;
    dma_pkg::beat_cnt_t rd_left_q;
    dma_pkg::beat_cnt_t out_left_q;
    dma_pkg::ram_idx_t  rd_idx_q;
    dma_pkg::tlp_beat_t hold_data_q;
    dma_pkg::tlp_beat_t hdr_beat;
    dma_pkg::dw_len_t   hdr_len;
    logic               hold_vld_q;
    logic               rd_pend_q;
    logic               done_q;
    logic               idle;
    logic               load;
    logic               acc;
    logic               out_free;
    logic               out_from_hold;
    logic               out_from_rd;
    logic               hold_from_rd;
    logic               rd_more;
    logic [1:0]         items;

    // count of 0 sends one beat, above the limit is capped
    assign start_cnt = (i_beat_cnt == '0) ? dma_pkg::beat_cnt_t'(1) :
                       (i_beat_cnt > dma_pkg::beat_cnt_t'(`DMA_MAX_BEATS)) ?
                       dma_pkg::beat_cnt_t'(`DMA_MAX_BEATS) : i_beat_cnt;
    assign hdr_len   = dma_pkg::dw_len_t'(start_cnt) << 2;

    always_comb
    begin
        hdr_beat         = '0;
        hdr_beat[7:0]    = `DMA_TYPE_MWR32;
        hdr_beat[17:8]   = hdr_len;
        hdr_beat[63:32]  = i_dst_addr;
        // requester id, function 0
        hdr_beat[79:64]  = {i_cfg_pbus_num, i_cfg_pbus_dev_num, 3'b000};
    end

    // ********************
    // read scheduling
    assign idle     = (state_q == dma_pkg::TX_IDLE);
    assign load     = i_start;
    assign acc      = o_tvld & i_trdy;
    assign out_free = ~o_tvld | acc;

    // beats that still occupy a slot after this edge
    assign items   = {1'b0, o_tvld & ~i_trdy} + {1'b0, hold_vld_q} + {1'b0, rd_pend_q};
    assign rd_more = ~idle & (rd_left_q != '0) & (items <= 2'd1);

    assign o_rd_en  = load | rd_more;
    assign o_rd_idx = idle ? i_src_idx : rd_idx_q;

    assign out_from_hold = ~idle & out_free & hold_vld_q;
    assign out_from_rd   = ~idle & out_free & ~hold_vld_q & rd_pend_q;
    assign hold_from_rd  = ~idle & rd_pend_q & ~out_from_rd;

    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            state_q    <= dma_pkg::TX_IDLE;
            o_tvld     <= 1'b0;
            o_tlast    <= 1'b0;
            hold_vld_q <= 1'b0;
            rd_pend_q  <= 1'b0;
            rd_left_q  <= '0;
            out_left_q <= '0;
            rd_idx_q   <= '0;
            done_q     <= 1'b0;
        end
        else
        begin
            rd_pend_q <= o_rd_en;
            done_q    <= acc & o_tlast;
            if (load)
            begin
                state_q    <= dma_pkg::TX_HDR;
                o_tvld     <= 1'b1;
                o_tlast    <= 1'b0;
                hold_vld_q <= 1'b0;
                rd_left_q  <= start_cnt - 1'b1;
                out_left_q <= start_cnt;
                rd_idx_q   <= i_src_idx + 1'b1;
            end
            else if (!idle)
            begin
                if (out_from_hold || out_from_rd)
                begin
                    o_tvld     <= 1'b1;
                    o_tlast    <= (out_left_q == dma_pkg::beat_cnt_t'(1));
                    out_left_q <= out_left_q - 1'b1;
                end
                else if (out_free)
                begin
                    o_tvld  <= 1'b0;
                    o_tlast <= 1'b0;
                end
                if (out_from_hold)
                begin
                    hold_vld_q <= rd_pend_q;
                end
                else if (hold_from_rd)
                begin
                    hold_vld_q <= 1'b1;
                end
                if (rd_more)
                begin
                    rd_left_q <= rd_left_q - 1'b1;
                    rd_idx_q  <= rd_idx_q + 1'b1;
                end
                if (state_q == dma_pkg::TX_HDR && acc)
                begin
                    state_q <= dma_pkg::TX_DATA;
                end
                else if (state_q == dma_pkg::TX_DATA && acc && o_tlast)
                begin
                    state_q <= dma_pkg::TX_IDLE;
                end
            end
        end
    end

    // beat payload
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            o_tdata <= hdr_beat;
        end
        else if (out_from_hold)
        begin
            o_tdata <= hold_data_q;
        end
        else if (out_from_rd)
        begin
            o_tdata <= i_rd_data;
        end
        if (hold_from_rd || (out_from_hold && rd_pend_q))
        begin
            hold_data_q <= i_rd_data;
        end
    end

    assign o_busy    = ~idle;
    assign o_tx_done = done_q;

endmodule

//--- rtl/dma_apb_regs.sv
`timescale 1ns/1ps
`include "dma_defs.svh"

module dma_apb_regs (
    input  logic                clk,
    input  logic                i_arst_n,
    input  logic                i_apb_psel,
    input  dma_pkg::apb_addr_t  i_apb_paddr,
    input  dma_pkg::apb_data_t  i_apb_pwdata,
    input  logic                i_apb_pwrite,
    input  logic                i_apb_penable,
    input  logic                i_tx_busy,
    input  logic                i_tx_done,
    input  logic                i_rx_done,
    output logic                o_apb_prdy,
    output dma_pkg::apb_data_t  o_apb_prdata,
    output logic                o_start,
    output dma_pkg::host_addr_t o_dst_addr,
    output dma_pkg::ram_idx_t   o_src_idx,
    output dma_pkg::beat_cnt_t  o_beat_cnt
);

    dma_pkg::host_addr_t dst_q;
    dma_pkg::ram_idx_t   src_idx_q;
    dma_pkg::beat_cnt_t  beat_cnt_q;
    dma_pkg::tlp_cnt_t   done_cnt_q;
    dma_pkg::tlp_cnt_t   rx_cnt_q;
    logic                start_q;
    logic                access;
    logic                wr_access;
    logic                busy_flag;
    logic                start_req;

    assign access    = i_apb_psel & i_apb_penable;
    assign wr_access = access & i_apb_pwrite;

    // a start still pending counts as busy
    assign busy_flag = i_tx_busy | start_q;
    assign start_req = wr_access & (i_apb_paddr == `DMA_REG_CTRL) &
                       i_apb_pwdata[0] & ~busy_flag;

    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            dst_q      <= '0;
            src_idx_q  <= '0;
            beat_cnt_q <= '0;
            start_q    <= 1'b0;
            done_cnt_q <= '0;
            rx_cnt_q   <= '0;
        end
        else
        begin
            start_q <= start_req;
            if (wr_access && (i_apb_paddr == `DMA_REG_DST))
            begin
                dst_q <= i_apb_pwdata;
            end
            if (wr_access && (i_apb_paddr == `DMA_REG_SRC))
            begin
                src_idx_q  <= i_apb_pwdata[5:0];
                beat_cnt_q <= i_apb_pwdata[12:8];
            end
            // ********************
            // tlp counters
            if (i_tx_done)
            begin
                done_cnt_q <= done_cnt_q + 1'b1;
            end
            if (i_rx_done)
            begin
                rx_cnt_q <= rx_cnt_q + 1'b1;
            end
        end
    end

    // no wait states
    always_comb
    begin
        o_apb_prdata = '0;
        if (access)
        begin
            case (i_apb_paddr)
                `DMA_REG_CTRL:     o_apb_prdata[0]     = busy_flag;
                `DMA_REG_DST:      o_apb_prdata        = dst_q;
                `DMA_REG_SRC:
                begin
                    o_apb_prdata[5:0]  = src_idx_q;
                    o_apb_prdata[12:8] = beat_cnt_q;
                end
                `DMA_REG_DONE_CNT: o_apb_prdata[15:0]  = done_cnt_q;
                `DMA_REG_RX_CNT:   o_apb_prdata[15:0]  = rx_cnt_q;
                default:           o_apb_prdata        = '0;
            endcase
        end
    end

    assign o_apb_prdy = access;
    assign o_start    = start_q;
    assign o_dst_addr = dst_q;
    assign o_src_idx  = src_idx_q;
    assign o_beat_cnt = beat_cnt_q;

endmodule

//--- rtl/dma_rx_ctrl.sv
`timescale 1ns/1ps
`include "dma_defs.svh"

module dma_rx_ctrl (
    input  logic               clk,
    input  logic               i_arst_n,
    input  logic               i_tvld,
    input  dma_pkg::tlp_beat_t i_tdata,
    input  logic               i_tlast,
    output logic               o_trdy,
    output logic               o_wr_en,
    output dma_pkg::ram_idx_t  o_wr_idx,
    output dma_pkg::tlp_beat_t o_wr_data,
    output logic               o_rx_done
);

    dma_pkg::rx_state_t state_q;
    dma_pkg::ram_idx_t  wr_idx_q;
    logic               trdy_q;
    logic               beat;
    logic               hdr_is_mwr;

    assign beat       = i_tvld & trdy_q;
    assign hdr_is_mwr = (i_tdata[7:0] == `DMA_TYPE_MWR32);

    // ********************
    // header decode and line stepping
    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            state_q  <= dma_pkg::RX_IDLE;
            wr_idx_q <= '0;
            trdy_q   <= 1'b0;
        end
        else
        begin
            // never back-pressures once out of reset
            trdy_q <= 1'b1;
            if (beat)
            begin
                case (state_q)
                    dma_pkg::RX_IDLE:
                    begin
                        // start line is byte address / 16, mod 64
                        wr_idx_q <= i_tdata[41:36];
                        if (!i_tlast)
                        begin
                            state_q <= hdr_is_mwr ? dma_pkg::RX_DATA : dma_pkg::RX_DROP;
                        end
                    end
                    dma_pkg::RX_DATA:
                    begin
                        wr_idx_q <= wr_idx_q + 1'b1;
                        if (i_tlast)
                        begin
                            state_q <= dma_pkg::RX_IDLE;
                        end
                    end
                    default:
                    begin
                        if (i_tlast)
                        begin
                            state_q <= dma_pkg::RX_IDLE;
                        end
                    end
                endcase
            end
        end
    end

    // write happens on the edge that takes the data beat
    assign o_trdy    = trdy_q;
    assign o_wr_en   = beat & (state_q == dma_pkg::RX_DATA);
    assign o_wr_idx  = wr_idx_q;
    assign o_wr_data = i_tdata;
    assign o_rx_done = beat & i_tlast &
                       ((state_q == dma_pkg::RX_DATA) |
                        ((state_q == dma_pkg::RX_IDLE) & hdr_is_mwr));

endmodule

//--- rtl/dma_bar_ram.sv
`timescale 1ns/1ps
`include "dma_defs.svh"

module dma_bar_ram (
    input  logic              clk,
    input  logic              i_wr_en,
    input  dma_pkg::ram_idx_t i_wr_idx,
    input  dma_pkg::tlp_beat_t i_wr_data,
    input  logic              i_rd_en,
    input  dma_pkg::ram_idx_t i_rd_idx,
    output dma_pkg::tlp_beat_t o_rd_data
);

    dma_pkg::tlp_beat_t mem [`DMA_RAM_DEPTH];
    dma_pkg::tlp_beat_t rd_data_q;

    // full-line writes from the rx side
    always_ff @(posedge clk)
    begin
        if (i_wr_en)
        begin
            mem[i_wr_idx] <= i_wr_data;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk)
    begin
        if (i_rd_en)
        begin
            rd_data_q <= mem[i_rd_idx];
        end
    end

    assign o_rd_data = rd_data_q;

endmodule

//--- rtl/dma_pkg.sv
package dma_pkg;

    // stream and memory widths
    typedef logic [127:0] tlp_beat_t;
    typedef logic [5:0]   ram_idx_t;
    typedef logic [4:0]   beat_cnt_t;
    typedef logic [9:0]   dw_len_t;
    typedef logic [31:0]  host_addr_t;

    // register bus
    typedef logic [8:0]   apb_addr_t;
    typedef logic [31:0]  apb_data_t;
    typedef logic [15:0]  tlp_cnt_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_HDR,
        TX_DATA
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_DATA,
        RX_DROP
    } rx_state_t;

endpackage

//--- rtl/dma_defs.svh
`ifndef DMA_DEFS_SVH
`define DMA_DEFS_SVH

// ********************
// BAR memory
`define DMA_RAM_DEPTH       64

// ********************
// TLP header
`define DMA_TYPE_MWR32      8'h40
`define DMA_MAX_BEATS       16

// ********************
// APB register byte offsets
`define DMA_REG_CTRL        9'h000
`define DMA_REG_DST         9'h004
`define DMA_REG_SRC         9'h008
`define DMA_REG_DONE_CNT    9'h00C
`define DMA_REG_RX_CNT      9'h010

`endif
